//--- verilog/game_rules_pkg.sv
`default_nettype none

package game_rules_pkg;

	// Lives at the start of a game.
	localparam logic [3:0] LIFE_INIT = 4'd3;

	// Good hits needed to finish a level.
	localparam logic [3:0] SCORE_TO_ADVANCE = 4'd2;

	// Rows gained per lift key.
	localparam int unsigned LIFT_ROWS = 2;

	typedef enum logic [1:0] {
		ST_READY,	// Waiting for start, level held in reset.
		ST_PLAY,
		ST_OVER	// No lives left.
	} game_state_t;

endpackage

`default_nettype wire

//--- verilog/grid_pkg.sv
`default_nettype none

package grid_pkg;

	localparam int unsigned GRID_COLS = 8;
	localparam int unsigned GRID_ROWS = 16;
	localparam int unsigned ROW_W = 4;
	localparam int unsigned COL_W = 3;

	localparam int unsigned N_OBST = 4;

	// Each obstacle falls down its own column.
	localparam logic [COL_W-1:0] OBST_COL [N_OBST] = '{3'd1, 3'd3, 3'd5, 3'd7};
	localparam logic [ROW_W-1:0] OBST_START_ROW [N_OBST] = '{4'd0, 4'd4, 4'd8, 4'd12};

	localparam logic [COL_W-1:0] SMILEY_START_COL = 3'd0;
	localparam logic [ROW_W-1:0] SMILEY_START_ROW = 4'd0;

endpackage

`default_nettype wire

//--- verilog/obst_if.sv
`timescale 1ns/10ps
`default_nettype none

interface obst_if import grid_pkg::*; ();

	logic [N_OBST-1:0][ROW_W-1:0] obst_row;
	logic [N_OBST-1:0] obst_kind;	// Set for a good obstacle.
	logic [N_OBST-1:0] obst_valid;
	logic [N_OBST-1:0] hit_clear;	// Respawn request, one cycle.

	modport field (
		output obst_row, obst_kind, obst_valid,
		input hit_clear
	);

	modport detector (
		input obst_row, obst_kind, obst_valid,
		output hit_clear
	);

endinterface

`default_nettype wire

//--- verilog/collision_if.sv
`timescale 1ns/10ps
`default_nettype none

interface collision_if ();

	logic border_bottom;
	logic obstacle_real;
	logic obstacle_good;	// Qualified by obstacle_real.
	logic obstacle_bad;	// Qualified by obstacle_real.

	modport detector (
		output border_bottom, obstacle_real, obstacle_good, obstacle_bad
	);

	modport controller (
		input border_bottom, obstacle_real, obstacle_good, obstacle_bad
	);

endinterface

`default_nettype wire

//--- verilog/smiley_mover.sv
`timescale 1ns/10ps
`default_nettype none

module smiley_mover import grid_pkg::*, game_rules_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic pause,
	input logic reset_level,
	output logic [ROW_W-1:0] smiley_row,
	output logic [COL_W-1:0] smiley_col
);

	logic [ROW_W-1:0] row_next;
	logic [COL_W-1:0] col_next;

	always_comb begin
		col_next = smiley_col;
		if (key_left && !key_right && smiley_col != '0) begin
			col_next = smiley_col - 1'b1;
		end
		else if (key_right && !key_left && smiley_col != COL_W'(GRID_COLS - 1)) begin
			col_next = smiley_col + 1'b1;
		end

		row_next = smiley_row;
		if (key_up) begin
			if (smiley_row < ROW_W'(LIFT_ROWS)) begin
				row_next = '0;	// Clamp at the top row.
			end
			else begin
				row_next = smiley_row - ROW_W'(LIFT_ROWS);
			end
		end
		else if (smiley_row != ROW_W'(GRID_ROWS - 1)) begin
			row_next = smiley_row + 1'b1;	// Gravity.
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			smiley_row <= SMILEY_START_ROW;
			smiley_col <= SMILEY_START_COL;
		end
		else if (reset_level) begin
			smiley_row <= SMILEY_START_ROW;
			smiley_col <= SMILEY_START_COL;
		end
		else if (frame_tick && !pause) begin
			smiley_row <= row_next;
			smiley_col <= col_next;
		end
	end

	// Column never wraps at an edge.
	a_col_in_grid: assert property (@(posedge clk) disable iff (!resetN)
		!reset_level |=> (int'(smiley_col) <= int'($past(smiley_col)) + 1) &&
			(int'(smiley_col) + 1 >= int'($past(smiley_col))));

endmodule

`default_nettype wire

//--- verilog/obstacle_field.sv
`timescale 1ns/10ps
`default_nettype none

module obstacle_field import grid_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	input logic pause,
	input logic reset_level,
	input logic [N_OBST-1:0] obst_kind_cfg,
	obst_if.field ob
);

	logic step;

	assign step = frame_tick && !pause;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < N_OBST; i++) begin
				ob.obst_row[i] <= OBST_START_ROW[i];
			end
			ob.obst_kind <= '0;
			ob.obst_valid <= '0;	// Armed by the first level reset.
		end
		else begin
			for (int i = 0; i < N_OBST; i++) begin
				if (reset_level) begin
					ob.obst_row[i] <= OBST_START_ROW[i];
					ob.obst_kind[i] <= obst_kind_cfg[i];
					ob.obst_valid[i] <= 1'b1;
				end
				else if (ob.hit_clear[i]) begin
					ob.obst_row[i] <= '0;	// Respawn at the top.
					ob.obst_kind[i] <= obst_kind_cfg[i];
				end
				else if (step) begin
					if (ob.obst_row[i] == ROW_W'(GRID_ROWS - 1)) begin
						ob.obst_row[i] <= '0;
						ob.obst_kind[i] <= obst_kind_cfg[i];	// New kind on wrap.
					end
					else begin
						ob.obst_row[i] <= ob.obst_row[i] + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/collision_detector.sv
`timescale 1ns/10ps
`default_nettype none

module collision_detector import grid_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	input logic [ROW_W-1:0] smiley_row,
	input logic [COL_W-1:0] smiley_col,
	obst_if.detector ob,
	collision_if.detector cl
);

	logic tick_d;	// Positions are fresh in this cycle.
	logic border_hit;
	logic [N_OBST-1:0] touch;
	logic [N_OBST-1:0] first_touch;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tick_d <= 1'b0;
		end
		else begin
			tick_d <= frame_tick;
		end
	end

	assign border_hit = tick_d && (smiley_row == ROW_W'(GRID_ROWS - 1));

	always_comb begin
		for (int i = 0; i < N_OBST; i++) begin
			touch[i] = tick_d && ob.obst_valid[i] && (ob.obst_row[i] == smiley_row) &&
				(OBST_COL[i] == smiley_col);
		end
		first_touch = touch & (~touch + 1'b1);	// Lowest index wins.
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cl.border_bottom <= 1'b0;
			cl.obstacle_real <= 1'b0;
			cl.obstacle_good <= 1'b0;
			cl.obstacle_bad <= 1'b0;
			ob.hit_clear <= '0;
		end
		else begin
			cl.border_bottom <= border_hit;
			cl.obstacle_real <= !border_hit && (|touch);
			cl.obstacle_good <= !border_hit && (|(first_touch & ob.obst_kind));
			cl.obstacle_bad <= !border_hit && (|(first_touch & ~ob.obst_kind));
			ob.hit_clear <= border_hit ? '0 : first_touch;
		end
	end

	a_clear_onehot: assert property (@(posedge clk) disable iff (!resetN)
		$onehot0(ob.hit_clear));

endmodule

`default_nettype wire

//--- verilog/game_controller.sv
`timescale 1ns/10ps
`default_nettype none

module game_controller import game_rules_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic key_start,
	collision_if.controller cl,
	output logic pause,
	output logic reset_level,
	output logic [3:0] score,
	output logic [3:0] level,
	output logic [3:0] life,
	output game_state_t state
);

	game_state_t state_next;
	logic [3:0] score_next;
	logic [3:0] level_next;
	logic [3:0] life_next;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= ST_READY;
			score <= '0;
			level <= '0;
			life <= LIFE_INIT;
		end
		else begin
			state <= state_next;
			score <= score_next;
			level <= level_next;
			life <= life_next;
		end
	end

	always_comb begin
		state_next = state;
		score_next = score;
		level_next = level;
		life_next = life;
		pause = 1'b1;
		reset_level = 1'b0;

		case (state)
			ST_READY: begin
				score_next = '0;
				reset_level = 1'b1;
				if (key_start) begin
					state_next = ST_PLAY;
				end
			end
			ST_PLAY: begin
				pause = 1'b0;
				if (cl.border_bottom) begin
					life_next = life - 1'b1;
					state_next = (life_next == '0) ? ST_OVER : ST_READY;
				end
				else if (cl.obstacle_real && cl.obstacle_good) begin
					if (score == SCORE_TO_ADVANCE - 1'b1) begin
						level_next = level + 1'b1;	// Level done.
						state_next = ST_READY;
					end
					else begin
						score_next = score + 1'b1;
					end
				end
				else if (cl.obstacle_real && cl.obstacle_bad && score != '0) begin
					score_next = score - 1'b1;	// Floor at zero.
				end
			end
			ST_OVER: begin
				score_next = '0;
				level_next = '0;
				life_next = LIFE_INIT;
				reset_level = 1'b1;
				if (key_start) begin
					state_next = ST_PLAY;
				end
			end
			default: state_next = ST_READY;
		endcase
	end

	a_life_max: assert property (@(posedge clk) disable iff (!resetN)
		life <= LIFE_INIT);

endmodule

`default_nettype wire

//--- verilog/game_regs.sv
`timescale 1ns/10ps
`default_nettype none

module game_regs import grid_pkg::*, game_rules_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [3:0] score,
	input logic [3:0] level,
	input logic [3:0] life,
	input game_state_t state,
	output logic [N_OBST-1:0] obst_kind_cfg
);

	logic setup_phase;
	logic access_phase;
	logic addr_ok;
	logic [31:0] read_data;

	assign setup_phase = psel && !penable;
	assign access_phase = psel && penable;
	assign pready = 1'b1;	// No wait states.

	always_comb begin
		addr_ok = 1'b1;
		read_data = '0;
		case (paddr)
			4'h0: read_data = {18'd0, state, life, level, score};
			4'h4: read_data = {{(32 - N_OBST){1'b0}}, obst_kind_cfg};
			default: addr_ok = 1'b0;
		endcase
	end

	// Read data and error are captured in setup and shown in access.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			prdata <= '0;
			pslverr <= 1'b0;
			obst_kind_cfg <= 4'b0101;
		end
		else begin
			pslverr <= setup_phase && !addr_ok;
			if (setup_phase && !pwrite) begin
				prdata <= read_data;
			end
			if (access_phase && pwrite && paddr == 4'h4) begin
				obst_kind_cfg <= pwdata[N_OBST-1:0];
			end
		end
	end

	a_slverr_access: assert property (@(posedge clk) disable iff (!resetN)
		pslverr |-> access_phase);

endmodule

`default_nettype wire

//--- verilog/game_top.sv
`timescale 1ns/10ps
`default_nettype none

module game_top import grid_pkg::*, game_rules_pkg::*; (
	input logic clk,
	input logic resetN,
	input logic frame_tick,
	input logic key_left,
	input logic key_right,
	input logic key_up,
	input logic key_start,
	input logic [3:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [3:0] score,
	output logic [3:0] level,
	output logic [3:0] life,
	output logic pause
);

	logic reset_level;
	logic [ROW_W-1:0] smiley_row;
	logic [COL_W-1:0] smiley_col;
	logic [N_OBST-1:0] obst_kind_cfg;
	game_state_t state;

	obst_if obst_bus ();
	collision_if coll_bus ();

	smiley_mover i_mover (
		.clk, .resetN, .frame_tick, .key_left, .key_right, .key_up,
		.pause, .reset_level, .smiley_row, .smiley_col
	);

	obstacle_field i_field (
		.clk, .resetN, .frame_tick, .pause, .reset_level, .obst_kind_cfg,
		.ob(obst_bus)
	);

	collision_detector i_detector (
		.clk, .resetN, .frame_tick, .smiley_row, .smiley_col,
		.ob(obst_bus), .cl(coll_bus)
	);

	game_controller i_ctrl (
		.clk, .resetN, .key_start, .cl(coll_bus),
		.pause, .reset_level, .score, .level, .life, .state
	);

	game_regs i_regs (
		.clk, .resetN, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .score, .level, .life, .state, .obst_kind_cfg
	);

endmodule

`default_nettype wire

//--- verif/game_model.svh
logic [ROW_W-1:0] m_row;
logic [COL_W-1:0] m_col;
logic [ROW_W-1:0] m_obst_row [N_OBST];
logic [N_OBST-1:0] m_kind;
logic [N_OBST-1:0] m_cfg;
game_state_t m_state;
logic [3:0] m_score;
logic [3:0] m_level;
logic [3:0] m_life;
int m_good;
int m_bad;
int m_overs;

function automatic void restart_level();
	m_row = SMILEY_START_ROW;
	m_col = SMILEY_START_COL;
	for (int i = 0; i < N_OBST; i++) begin
		m_obst_row[i] = OBST_START_ROW[i];
	end
	m_kind = m_cfg;
	m_score = '0;
endfunction

function automatic void init_model();
	m_cfg = 4'b0101;
	m_state = ST_READY;
	m_level = '0;
	m_life = LIFE_INIT;
	m_good = 0;
	m_bad = 0;
	m_overs = 0;
	restart_level();
endfunction

function automatic void start_game();
	m_state = ST_PLAY;
	restart_level();
endfunction

function automatic void lose_life();
	m_life = m_life - 4'd1;
	if (m_life == '0) begin
		m_state = ST_OVER;
		m_level = '0;
		m_life = LIFE_INIT;	// Restored while waiting for start.
		m_overs++;
	end
	else begin
		m_state = ST_READY;
	end
	restart_level();
endfunction

function automatic void step_frame(input logic left, input logic right, input logic up);
	int hit;
	if (m_state != ST_PLAY) begin
		return;	// Paused.
	end
	if (left && !right && m_col != 3'd0) begin
		m_col = m_col - 3'd1;
	end
	else if (right && !left && m_col != COL_W'(GRID_COLS - 1)) begin
		m_col = m_col + 3'd1;
	end
	if (up) begin
		m_row = (m_row < ROW_W'(LIFT_ROWS)) ? '0 : m_row - ROW_W'(LIFT_ROWS);
	end
	else if (m_row != ROW_W'(GRID_ROWS - 1)) begin
		m_row = m_row + 4'd1;
	end
	for (int i = 0; i < N_OBST; i++) begin
		if (m_obst_row[i] == ROW_W'(GRID_ROWS - 1)) begin
			m_obst_row[i] = '0;
			m_kind[i] = m_cfg[i];
		end
		else begin
			m_obst_row[i] = m_obst_row[i] + 4'd1;
		end
	end
	if (m_row == ROW_W'(GRID_ROWS - 1)) begin
		lose_life();	// Bottom border wins over any obstacle.
		return;
	end
	hit = -1;
	for (int i = N_OBST - 1; i >= 0; i--) begin
		if (m_obst_row[i] == m_row && OBST_COL[i] == m_col) begin
			hit = i;
		end
	end
	if (hit < 0) begin
		return;
	end
	if (m_kind[hit]) begin
		m_good++;
		if (m_score == SCORE_TO_ADVANCE - 4'd1) begin
			m_level = m_level + 4'd1;
			m_state = ST_READY;
			restart_level();
			return;
		end
		m_score = m_score + 4'd1;
	end
	else begin
		m_bad++;
		if (m_score != '0) begin
			m_score = m_score - 4'd1;
		end
	end
	m_obst_row[hit] = '0;
	m_kind[hit] = m_cfg[hit];
endfunction

//--- verif/game_tb.sv
`timescale 1ns/10ps
`default_nettype none

module game_tb import grid_pkg::*, game_rules_pkg::*; ();

	logic clk = 1'b0;
	logic resetN;
	logic frame_tick;
	logic key_left;
	logic key_right;
	logic key_up;
	logic key_start;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [3:0] score;
	logic [3:0] level;
	logic [3:0] life;
	logic pause;

	int n_errors;
	int n_checks;

	`include "game_model.svh"

	game_top i_dut (.*);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [3:0] got, input logic [3:0] exp);
		n_checks++;
		assert (got == exp) else begin
			n_errors++;
			$display("MISMATCH at %0t ns: %s got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic apb_transfer(input logic [3:0] addr, input logic is_write,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge clk);
		paddr <= addr;
		pwrite <= is_write;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		waited = 0;
		while (!pready && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		assert (pready) else begin
			n_errors++;
			$display("APB transfer to address %0h never got pready", addr);
		end
		rdata = prdata;	// Sampled mid access phase.
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_status();
		logic [31:0] data;
		logic err;
		apb_transfer(4'h0, 1'b0, '0, data, err);
		check_value("pslverr", {3'b0, err}, 4'd0);
		check_value("status.score", data[3:0], m_score);
		check_value("status.level", data[7:4], m_level);
		check_value("status.life", data[11:8], m_life);
		check_value("status.state", {2'b0, data[13:12]}, {2'b0, m_state});
	endtask

	task automatic check_outputs();
		check_value("score", score, m_score);
		check_value("level", level, m_level);
		check_value("life", life, m_life);
		check_value("pause", {3'b0, pause}, {3'b0, m_state != ST_PLAY});
		check_value("smiley_row", i_dut.smiley_row, m_row);
		check_value("smiley_col", {1'b0, i_dut.smiley_col}, {1'b0, m_col});
	endtask

	task automatic write_kind(input logic [31:0] word);
		logic [31:0] data;
		logic err;
		apb_transfer(4'h4, 1'b1, word, data, err);
		m_cfg = word[3:0];
		apb_transfer(4'h4, 1'b0, '0, data, err);
		check_value("obst_kind", data[3:0], word[3:0]);
		check_value("pslverr", {3'b0, err}, 4'd0);
	endtask

	task automatic play_tick();
		logic [31:0] r;
		logic left;
		logic right;
		logic up;
		r = $urandom;
		left = r[0];
		right = r[1];
		up = (r[3:2] == 2'b00);	// Lift one tick in four.
		@(posedge clk);
		frame_tick <= 1'b1;
		key_left <= left;
		key_right <= right;
		key_up <= up;
		@(posedge clk);
		frame_tick <= 1'b0;
		key_left <= 1'b0;
		key_right <= 1'b0;
		key_up <= 1'b0;
		step_frame(left, right, up);
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_outputs();
		check_status();
	endtask

	task automatic press_start();
		int waited;
		@(posedge clk);
		key_start <= 1'b1;
		@(posedge clk);
		key_start <= 1'b0;
		start_game();
		waited = 0;
		@(negedge clk);
		while (pause && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		assert (!pause) else begin
			n_errors++;
			$display("Game did not start after key_start");
		end
	endtask

	initial begin
		logic [31:0] data;
		logic err;
		int ticks;
		resetN = 1'b0;
		frame_tick = 1'b0;
		key_left = 1'b0;
		key_right = 1'b0;
		key_up = 1'b0;
		key_start = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		n_errors = 0;
		n_checks = 0;
		void'($urandom(11115));
		init_model();
		repeat (10) @(posedge clk);
		resetN <= 1'b1;
		@(negedge clk);
		check_outputs();
		check_status();
		play_tick();	// Still in ready, nothing moves.
		apb_transfer(4'h8, 1'b0, '0, data, err);
		check_value("pslverr", {3'b0, err}, 4'd1);
		apb_transfer(4'hC, 1'b1, $urandom, data, err);
		check_value("pslverr", {3'b0, err}, 4'd1);
		for (int round = 0; round < 40; round++) begin
			write_kind($urandom);
			press_start();
			ticks = 0;
			while (m_state == ST_PLAY && ticks < 400) begin
				play_tick();
				ticks++;
			end
			assert (m_state != ST_PLAY) else begin
				n_errors++;
				$display("Round %0d did not end within 400 ticks", round);
			end
		end
		$display("Checks: %0d, errors: %0d, good hits: %0d, bad hits: %0d, games over: %0d",
			n_checks, n_errors, m_good, m_bad, m_overs);
		if (n_errors == 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
verilog/game_rules_pkg.sv
verilog/grid_pkg.sv
verilog/obst_if.sv
verilog/collision_if.sv
verilog/smiley_mover.sv
verilog/obstacle_field.sv
verilog/collision_detector.sv
verilog/game_controller.sv
verilog/game_regs.sv
verilog/game_top.sv
verif/game_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module game_tb -f filelist.f -o game_sim
status=0
./obj_dir/game_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "SIMULATION FAILED" sim.log; then
	echo "Run failed, see sim.log"
	exit 1
fi
echo "Run finished without failures"
